// ==== sd_cmd_top.f ====
sdhci_pkg.sv
crc7.sv
cmd_write.sv
rsp_read.sv
cmd_logic.sv
sd_cmd_top.sv
tb_sd_cmd_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and fail if the log reports a failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sd_cmd_top.f --top-module tb_sd_cmd_top -o tb_sim \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation done"
grep -q "RESULT: PASS" sim.log || { echo "no pass line in sim.log"; exit 1; }

// ==== tb_sd_cmd_top.sv ====
/*
 * Self-checking testbench for the SD command-line engine. A behavioral card
 * decodes each command frame and answers per a table row, and the host side
 * checks results, timing, busy handling and cooldown.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_sd_cmd_top;

  import sdhci_pkg::*;

  localparam int ROWS        = 10;
  localparam int CYCLE_LIMIT = ROWS * 400;

  // Card behaviors
  localparam int B_SILENT = 0;
  localparam int B_R1     = 1;
  localparam int B_R1B    = 2;
  localparam int B_R2     = 3;
  localparam int B_BADCRC = 4;
  localparam int B_BADIDX = 5;
  localparam int B_BADEND = 6;

  logic     clk_i       = 1'b0;
  logic     arst_n_i    = 1'b0;
  logic     clk_en_i    = 1'b0;
  logic     cmd_valid_i = 1'b0;
  cmd_req_t req_i       = '0;
  logic     sd_cmd_i    = 1'b1;
  logic     sd_busy_n_i = 1'b1;
  logic     cmd_ready_o;
  logic     cmd_done_o;
  logic     result_valid_o;
  rsp_t     rsp_o;
  rsp_err_t errors_o;
  logic     dat_busy_o;
  logic     sd_cmd_o;
  logic     sd_cmd_en_o;

  // Stimulus table
  cmd_t           t_idx[ROWS];
  cmd_arg_t       t_arg[ROWS];
  response_type_e t_type[ROWS];
  int             t_beh[ROWS];
  int             t_busy[ROWS];
  logic [119:0]   t_payload[ROWS];
  rsp_err_t       t_exp_err[ROWS];
  rsp_t           t_exp_rsp[ROWS];

  // Row currently served by the card
  int             cur_beh;
  int             cur_busy;
  int             cur_len;
  logic [135:0]   cur_reply;

  // Card state written only by the card process
  int             clk_cnt    = 0;
  int             card_state = 0;
  int             nbits      = 0;
  int             delay      = 0;
  int             pos        = 0;
  int             busy_left  = 0;
  int             frames_rx  = 0;
  int             last_evt   = 0;
  logic [47:0]    frame      = '0;
  logic [47:0]    frame_cap  = '0;
  logic           prev_en    = 1'b0;
  logic           tick_seen;

  int             seed = 41043;
  int             err_cnt = 0;
  int             rows_failed = 0;
  int             n_rows = 0;

  sd_cmd_top u_sd_cmd_top (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .clk_en_i       (clk_en_i),
    .cmd_valid_i    (cmd_valid_i),
    .req_i          (req_i),
    .sd_cmd_i       (sd_cmd_i),
    .sd_busy_n_i    (sd_busy_n_i),
    .cmd_ready_o    (cmd_ready_o),
    .cmd_done_o     (cmd_done_o),
    .result_valid_o (result_valid_o),
    .rsp_o          (rsp_o),
    .errors_o       (errors_o),
    .dat_busy_o     (dat_busy_o),
    .sd_cmd_o       (sd_cmd_o),
    .sd_cmd_en_o    (sd_cmd_en_o)
  );

  initial begin
    forever begin
      #5 clk_i = ~clk_i;
    end
  end

  // CRC7 over the lowest n bits of data MSB first with polynomial x^7+x^3+1
  function automatic logic [6:0] crc7_bits(input logic [135:0] data, input int n);
    logic [6:0] c;
    logic       fb;
    c = '0;
    for (int i = n - 1; i >= 0; i--) begin
      fb = data[i] ^ c[6];
      c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return c;
  endfunction

  task automatic check_value(input string name, input logic [119:0] got,
                             input logic [119:0] exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic add_row(input int r, input cmd_t idx, input cmd_arg_t arg,
                         input response_type_e typ, input int beh, input int busy);
    logic [127:0] rnd;
    cmd_t         echo;
    rsp_err_t     e;
    rnd          = {$random(seed), $random(seed), $random(seed), $random(seed)};
    echo         = (beh == B_BADIDX) ? (idx ^ 6'h01) : idx;
    t_idx[r]     = idx;
    t_arg[r]     = arg;
    t_type[r]    = typ;
    t_beh[r]     = beh;
    t_busy[r]    = busy;
    t_payload[r] = rnd[119:0];
    e             = '0;
    e.index_err   = (beh == B_BADIDX);
    e.crc_err     = (beh == B_BADCRC);
    e.end_bit_err = (beh == B_BADEND);
    e.timeout     = (beh == B_SILENT) && (typ != NO_RESPONSE);
    t_exp_err[r]  = e;
    if (typ == RESPONSE_LENGTH_136) begin
      t_exp_rsp[r].raw = rnd[119:0];
    end else begin
      t_exp_rsp[r].raw = {82'b0, echo, rnd[31:0]};
    end
  endtask

  // Card reply bits MSB first for the row's behavior
  task automatic build_reply(input int r);
    logic [39:0]  body;
    logic [6:0]   crc;
    logic [6:0]   bad;
    logic         endb;
    cmd_t         echo;
    bad  = (t_beh[r] == B_BADCRC) ? 7'h01 : 7'h00;
    endb = (t_beh[r] != B_BADEND);
    echo = (t_beh[r] == B_BADIDX) ? (t_idx[r] ^ 6'h01) : t_idx[r];
    if (t_type[r] == RESPONSE_LENGTH_136) begin
      crc       = crc7_bits({16'b0, t_payload[r]}, 120);
      cur_reply = {2'b00, 6'b111111, t_payload[r], crc ^ bad, endb};
      cur_len   = 136;
    end else begin
      body      = {2'b00, echo, t_payload[r][31:0]};
      crc       = crc7_bits({96'b0, body}, 40);
      cur_reply = {88'b0, body, crc ^ bad, endb};
      cur_len   = 48;
    end
    cur_beh  = t_beh[r];
    cur_busy = t_busy[r];
  endtask

  // Run limit
  always @(posedge clk_i) begin
    if (clk_cnt > CYCLE_LIMIT) begin
      $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // Clock enable and the card model on the falling edge
  always @(negedge clk_i) begin
    clk_cnt = clk_cnt + 1;
    tick_seen = clk_en_i;
    clk_en_i  = !clk_en_i;
    if (prev_en && !sd_cmd_en_o) begin
      last_evt = clk_cnt;
    end
    prev_en = sd_cmd_en_o;
    if (tick_seen) begin
      case (card_state)
        0: begin
          if (sd_cmd_en_o) begin
            frame = {frame[46:0], sd_cmd_o};
            nbits = nbits + 1;
            if (nbits == 48) begin
              nbits      = 0;
              frame_cap  = frame;
              frames_rx  = frames_rx + 1;
              delay      = 0;
              card_state = (cur_beh == B_SILENT) ? 0 : 1;
            end
          end
        end
        1: begin
          delay = delay + 1;
          if (delay == 4) begin
            sd_cmd_i   = cur_reply[cur_len - 1];
            pos        = 1;
            card_state = 2;
          end
        end
        2: begin
          if (pos == cur_len) begin
            sd_cmd_i   = 1'b1;
            last_evt   = clk_cnt;
            card_state = (cur_beh == B_R1B) ? 3 : 0;
          end else begin
            sd_cmd_i = cur_reply[cur_len - 1 - pos];
            if (pos == cur_len - 1 && cur_beh == B_R1B) begin
              // Card pulls DAT0 low together with the end bit
              sd_busy_n_i = 1'b0;
              busy_left   = cur_busy;
            end
            pos = pos + 1;
          end
        end
        default: begin
          busy_left = busy_left - 1;
          if (busy_left <= 0) begin
            sd_busy_n_i = 1'b1;
            last_evt    = clk_cnt;
            card_state  = 0;
          end
        end
      endcase
    end
  end

  initial begin
    int           errs_before;
    int           frames_before;
    int           done_n;
    int           res_n;
    int           done_clk;
    int           res_clk;
    int           ready_clk;
    int           cool;
    logic         left;
    logic         finished;
    logic [47:0]  exp_frame;
    logic [39:0]  fbody;

    add_row(0, 6'd0,  32'h0,        NO_RESPONSE,                   B_SILENT, 0);
    add_row(1, 6'd8,  32'h0000_01AA, RESPONSE_LENGTH_48,            B_R1,     0);
    add_row(2, 6'd2,  32'h0,        RESPONSE_LENGTH_136,           B_R2,     0);
    add_row(3, 6'd7,  32'h1234_0000, RESPONSE_LENGTH_48_CHECK_BUSY, B_R1B,    6);
    add_row(4, 6'd13, 32'h1234_0000, RESPONSE_LENGTH_48,            B_BADCRC, 0);
    add_row(5, 6'd17, 32'h0000_0200, RESPONSE_LENGTH_48,            B_BADIDX, 0);
    add_row(6, 6'd55, 32'h1234_0000, RESPONSE_LENGTH_48,            B_BADEND, 0);
    add_row(7, 6'd2,  32'h0,        RESPONSE_LENGTH_136,           B_SILENT, 0);
    add_row(8, 6'd16, 32'h0000_0200, RESPONSE_LENGTH_48,            B_SILENT, 0);
    add_row(9, 6'd3,  32'h0,        RESPONSE_LENGTH_48,            B_R1,     0);

    repeat (2) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    #1;
    check_value("cmd_ready_o", 120'(cmd_ready_o), 120'(1'b1));
    check_value("sd_cmd_en_o", 120'(sd_cmd_en_o), 120'(1'b0));
    check_value("sd_cmd_o", 120'(sd_cmd_o), 120'(1'b1));

    for (int r = 0; r < ROWS; r++) begin
      build_reply(r);
      errs_before   = err_cnt;
      frames_before = frames_rx;
      done_n        = 0;
      res_n         = 0;
      done_clk      = 0;
      res_clk       = 0;
      ready_clk     = 0;
      left          = 1'b0;
      finished      = 1'b0;
      @(negedge clk_i);
      cmd_valid_i = 1'b1;
      req_i       = '{index: t_idx[r], arg: t_arg[r], rsp_type: t_type[r]};
      while (!finished) begin
        @(negedge clk_i);
        cmd_valid_i = 1'b0;
        req_i       = '0;
        #1;
        if (cmd_done_o) begin
          done_n++;
          done_clk = clk_cnt;
        end
        if (result_valid_o) begin
          res_n++;
          res_clk = clk_cnt;
          check_value("errors_o", 120'(errors_o), 120'(t_exp_err[r]));
          if (!t_exp_err[r].timeout) begin
            check_value("rsp_o", rsp_o.raw, t_exp_rsp[r].raw);
          end
        end
        if (!sd_busy_n_i) begin
          check_value("dat_busy_o", 120'(dat_busy_o), 120'(1'b1));
          check_value("cmd_ready_o", 120'(cmd_ready_o), 120'(1'b0));
        end
        if (!cmd_ready_o) begin
          left = 1'b1;
        end else if (left) begin
          finished  = 1'b1;
          ready_clk = clk_cnt;
        end
      end

      // Frame as the card saw it
      fbody     = {2'b01, t_idx[r], t_arg[r]};
      exp_frame = {fbody, crc7_bits({96'b0, fbody}, 40), 1'b1};
      check_value("frames received", 120'(frames_rx - frames_before), 120'(1));
      check_value("sd_cmd_o frame", 120'(frame_cap), 120'(exp_frame));
      check_value("frame crc7", 120'(frame_cap[7:1]),
                  120'(crc7_bits({96'b0, fbody}, 40)));
      check_value("cmd_done_o pulses", 120'(done_n), 120'(1));
      check_value("result_valid_o pulses", 120'(res_n),
                  120'((t_type[r] == NO_RESPONSE) ? 0 : 1));

      if (t_exp_err[r].timeout) begin
        if (t_idx[r] == CMD_ALL_SEND_CID &&
            res_clk - done_clk > 2 * (int'(N_ID) + int'(N_CR_MIN) + 2)) begin
          $display("ERROR t=%0t CMD2 timeout pulse came too late", $time);
          err_cnt++;
        end
        if (t_idx[r] != CMD_ALL_SEND_CID && res_clk - done_clk <= 2 * int'(N_ID)) begin
          $display("ERROR t=%0t timeout pulse came too early", $time);
          err_cnt++;
        end
      end else begin
        cool = (t_type[r] == NO_RESPONSE) ? int'(N_CC) : int'(N_RC);
        if (ready_clk - last_evt < 2 * cool) begin
          $display("ERROR t=%0t cmd_ready_o returned before the bus cooldown", $time);
          err_cnt++;
        end
      end

      n_rows++;
      if (err_cnt != errs_before) begin
        rows_failed++;
        $display("row %0d CMD%0d failed", r, t_idx[r]);
      end else begin
        $display("row %0d CMD%0d ok", r, t_idx[r]);
      end
    end

    $display("rows run %0d, rows failed %0d, errors %0d", n_rows, rows_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sd_cmd_top.sv ====
/*
 * SD command-line engine. Host requests go in on a valid/ready pair and
 * results come back as a single-cycle pulse; the CMD and DAT0 pins face the card.
 */
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_top (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                clk_en_i,
  input  logic                cmd_valid_i,
  input  sdhci_pkg::cmd_req_t req_i,
  input  logic                sd_cmd_i,
  input  logic                sd_busy_n_i,
  output logic                cmd_ready_o,
  output logic                cmd_done_o,
  output logic                result_valid_o,
  output sdhci_pkg::rsp_t     rsp_o,
  output sdhci_pkg::rsp_err_t errors_o,
  output logic                dat_busy_o,
  output logic                sd_cmd_o,
  output logic                sd_cmd_en_o
);

  import sdhci_pkg::*;

  cmd_req_t req_latched;
  rsp_err_t rsp_err;
  logic     start_tx;
  logic     tx_done;
  logic     start_listen;
  logic     abort;
  logic     long_rsp;
  logic     receiving;
  logic     rsp_valid;

  cmd_logic u_cmd_logic (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .clk_en_i        (clk_en_i),
    .cmd_valid_i     (cmd_valid_i),
    .req_i           (req_i),
    .tx_done_i       (tx_done),
    .rsp_receiving_i (receiving),
    .rsp_valid_i     (rsp_valid),
    .rsp_err_i       (rsp_err),
    .sd_busy_n_i     (sd_busy_n_i),
    .cmd_ready_o     (cmd_ready_o),
    .req_o           (req_latched),
    .start_tx_o      (start_tx),
    .listen_o        (start_listen),
    .abort_o         (abort),
    .long_rsp_o      (long_rsp),
    .cmd_done_o      (cmd_done_o),
    .result_valid_o  (result_valid_o),
    .err_o           (errors_o),
    .dat_busy_o      (dat_busy_o)
  );

  cmd_write u_cmd_write (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .clk_en_i   (clk_en_i),
    .start_tx_i (start_tx),
    .req_i      (req_latched),
    .cmd_o      (sd_cmd_o),
    .cmd_en_o   (sd_cmd_en_o),
    .tx_done_o  (tx_done)
  );

  rsp_read u_rsp_read (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .clk_en_i    (clk_en_i),
    .cmd_i       (sd_cmd_i),
    .listen_i    (start_listen),
    .abort_i     (abort),
    .long_rsp_i  (long_rsp),
    .exp_index_i (req_latched.index),
    .receiving_o (receiving),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp_o),
    .err_o       (rsp_err)
  );

endmodule

`default_nettype wire

// ==== cmd_logic.sv ====
/*
 * Command sequencer. Accepts a host request, starts the serializer, arms
 * the response reader after N_CR_MIN ticks and enforces the response
 * timeout, the R1b busy wait and the bus cooldown before the next command.
 */
`timescale 1ns/1ps
`default_nettype none

module cmd_logic (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                clk_en_i,
  input  logic                cmd_valid_i,
  input  sdhci_pkg::cmd_req_t req_i,
  input  logic                tx_done_i,
  input  logic                rsp_receiving_i,
  input  logic                rsp_valid_i,
  input  sdhci_pkg::rsp_err_t rsp_err_i,
  input  logic                sd_busy_n_i,
  output logic                cmd_ready_o,
  output sdhci_pkg::cmd_req_t req_o,
  output logic                start_tx_o,
  output logic                listen_o,
  output logic                abort_o,
  output logic                long_rsp_o,
  output logic                cmd_done_o,
  output logic                result_valid_o,
  output sdhci_pkg::rsp_err_t err_o,
  output logic                dat_busy_o
);

  import sdhci_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    SEND_CMD,
    WAIT_RSP,
    READ_RSP,
    WAIT_BUSY,
    BUS_COOLDOWN,
    RSP_TIMEOUT
  } cmd_state_e;

  cmd_state_e state_q;
  cmd_state_e state_d;
  cmd_req_t   req_q;
  logic       start_q;
  logic [6:0] cycles_q;
  logic       accept;
  logic       clear_cnt;
  logic [6:0] cooldown_len;

  assign accept    = (state_q == IDLE) && cmd_valid_i;
  assign clear_cnt = (state_d == WAIT_RSP && state_q != WAIT_RSP) ||
                     (state_d == BUS_COOLDOWN && state_q != BUS_COOLDOWN);

  assign cooldown_len = (req_q.rsp_type == NO_RESPONSE) ? N_CC : N_RC;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = SEND_CMD;
        end
      end
      SEND_CMD: begin
        if (tx_done_i) begin
          state_d = (req_q.rsp_type == NO_RESPONSE) ? BUS_COOLDOWN : WAIT_RSP;
        end
      end
      WAIT_RSP: begin
        if (rsp_receiving_i) begin
          state_d = READ_RSP;
        end else if (req_q.index == CMD_ALL_SEND_CID && cycles_q == N_ID) begin
          // Identification response has its own short window
          state_d = RSP_TIMEOUT;
        end else if (cycles_q == N_CR_MAX) begin
          state_d = RSP_TIMEOUT;
        end
      end
      READ_RSP: begin
        if (rsp_valid_i) begin
          if (req_q.rsp_type == RESPONSE_LENGTH_48_CHECK_BUSY) begin
            state_d = WAIT_BUSY;
          end else begin
            state_d = BUS_COOLDOWN;
          end
        end
      end
      WAIT_BUSY: begin
        if (sd_busy_n_i) begin
          state_d = BUS_COOLDOWN;
        end
      end
      BUS_COOLDOWN: begin
        if (cycles_q == cooldown_len) begin
          state_d = IDLE;
        end
      end
      RSP_TIMEOUT: state_d = IDLE;
      default:     state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= IDLE;
      req_q    <= '0;
      start_q  <= 1'b0;
      cycles_q <= '0;
    end else begin
      state_q <= state_d;
      // Serializer starts one clock after acceptance, from the latched copy
      start_q <= accept;
      if (accept) begin
        req_q <= req_i;
      end
      if (clear_cnt) begin
        cycles_q <= '0;
      end else if (clk_en_i) begin
        cycles_q <= cycles_q + 7'd1;
      end
    end
  end

  // Timeout result carries only its own flag
  always_comb begin
    err_o = '0;
    if (state_q == RSP_TIMEOUT) begin
      err_o.timeout = 1'b1;
    end else begin
      err_o = rsp_err_i;
    end
  end

  assign cmd_ready_o    = state_q == IDLE;
  assign req_o          = req_q;
  assign start_tx_o     = start_q;
  assign listen_o       = (state_q == WAIT_RSP) && (cycles_q == N_CR_MIN);
  assign abort_o        = state_q == RSP_TIMEOUT;
  assign long_rsp_o     = req_q.rsp_type == RESPONSE_LENGTH_136;
  assign cmd_done_o     = (state_q == SEND_CMD) && tx_done_i;
  assign result_valid_o = ((state_q == READ_RSP) && rsp_valid_i) || (state_q == RSP_TIMEOUT);

  // R1b commands hold DAT0 from acceptance until the FSM is idle again
  assign dat_busy_o = (state_q != IDLE && req_q.rsp_type == RESPONSE_LENGTH_48_CHECK_BUSY) ||
                      (accept && req_i.rsp_type == RESPONSE_LENGTH_48_CHECK_BUSY);

endmodule

`default_nettype wire

// ==== rsp_read.sv ====
/*
 * CMD line deserializer for card responses. Armed by listen_i, it waits
 * for a start bit, then captures a 48-bit or 136-bit response and checks
 * CRC7, end bit and, for short responses, the echoed command index.
 */
`timescale 1ns/1ps
`default_nettype none

module rsp_read (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                clk_en_i,
  input  logic                cmd_i,
  input  logic                listen_i,
  input  logic                abort_i,
  input  logic                long_rsp_i,
  input  sdhci_pkg::cmd_t     exp_index_i,
  output logic                receiving_o,
  output logic                rsp_valid_o,
  output sdhci_pkg::rsp_t     rsp_o,
  output sdhci_pkg::rsp_err_t err_o
);

  import sdhci_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_ARMED,
    RX_RECV
  } rx_state_e;

  rx_state_e  state_q;
  logic [7:0] bit_pos_q;
  rsp_t       rsp_q;
  logic [6:0] rx_crc_q;
  logic       valid_q;
  rsp_err_t   err_q;

  logic [7:0] data_first;
  logic [7:0] crc_first;
  logic [7:0] end_pos;
  logic       tick_rx;
  logic       start_seen;
  logic       in_data;
  logic       in_crc;
  logic       at_end;
  logic [6:0] crc_calc;

  // Long responses skip start, transmission and six reserved bits.
  // Short ones skip only start and transmission; both are zero and do
  // not change the CRC.
  assign data_first = long_rsp_i ? 8'd8 : 8'd2;
  assign crc_first  = long_rsp_i ? 8'd128 : 8'd40;
  assign end_pos    = crc_first + 8'd7;

  assign tick_rx    = clk_en_i && (state_q == RX_RECV);
  assign start_seen = clk_en_i && (state_q == RX_ARMED) && !cmd_i;
  assign in_data    = (bit_pos_q >= data_first) && (bit_pos_q < crc_first);
  assign in_crc     = (bit_pos_q >= crc_first) && (bit_pos_q < end_pos);
  assign at_end     = bit_pos_q == end_pos;

  crc7 u_crc7 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .clr_i    (start_seen),
    .shift_i  (tick_rx && in_data),
    .bit_i    (cmd_i),
    .crc_o    (crc_calc)
  );

  // Cleared at the start bit so the short view gets its zero padding
  always_ff @(posedge clk_i) begin
    if (start_seen) begin
      rsp_q.raw <= '0;
    end else if (tick_rx && in_data) begin
      rsp_q.raw <= {rsp_q.raw[118:0], cmd_i};
    end
    if (tick_rx && in_crc) begin
      rx_crc_q <= {rx_crc_q[5:0], cmd_i};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= RX_IDLE;
      bit_pos_q <= '0;
      valid_q   <= 1'b0;
      err_q     <= '0;
    end else begin
      valid_q <= 1'b0;
      if (abort_i) begin
        state_q <= RX_IDLE;
      end else begin
        unique case (state_q)
          RX_IDLE: begin
            if (listen_i) begin
              state_q <= RX_ARMED;
            end
          end
          RX_ARMED: begin
            if (start_seen) begin
              state_q   <= RX_RECV;
              bit_pos_q <= 8'd1;
            end
          end
          RX_RECV: begin
            if (clk_en_i) begin
              if (at_end) begin
                state_q           <= RX_IDLE;
                valid_q           <= 1'b1;
                err_q.index_err   <= !long_rsp_i && (rsp_q.short_rsp.index != exp_index_i);
                err_q.crc_err     <= rx_crc_q != crc_calc;
                err_q.end_bit_err <= !cmd_i;
                err_q.timeout     <= 1'b0;
              end else begin
                bit_pos_q <= bit_pos_q + 8'd1;
              end
            end
          end
          default: state_q <= RX_IDLE;
        endcase
      end
    end
  end

  assign receiving_o = state_q == RX_RECV;
  assign rsp_valid_o = valid_q;
  assign rsp_o       = rsp_q;
  assign err_o       = err_q;

endmodule

`default_nettype wire

// ==== cmd_write.sv ====
/*
 * CMD line serializer. A start_tx_i pulse loads the request and the
 * 48-bit frame goes out MSB first, one bit per clk_en_i tick, with the
 * CRC7 computed on the fly. tx_done_o pulses once the end bit has been held.
 */
`timescale 1ns/1ps
`default_nettype none

module cmd_write (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                clk_en_i,
  input  logic                start_tx_i,
  input  sdhci_pkg::cmd_req_t req_i,
  output logic                cmd_o,
  output logic                cmd_en_o,
  output logic                tx_done_o
);

  logic [39:0] shift_q;
  logic [5:0]  bit_cnt_q;
  logic [5:0]  crc_pos;
  logic        busy_q;
  logic        cmd_q;
  logic        cmd_en_q;
  logic        tx_done_q;
  logic        tick;
  logic        in_body;
  logic        next_bit;
  logic [6:0]  crc;

  assign tick    = clk_en_i && busy_q;
  assign in_body = bit_cnt_q < 6'd40;
  assign crc_pos = bit_cnt_q - 6'd40;

  // Body bits, then the seven CRC bits, then the end bit
  always_comb begin
    if (in_body) begin
      next_bit = shift_q[39];
    end else if (bit_cnt_q < 6'd47) begin
      next_bit = crc[3'd6 - crc_pos[2:0]];
    end else begin
      next_bit = 1'b1;
    end
  end

  crc7 u_crc7 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .clr_i    (start_tx_i && !busy_q),
    .shift_i  (tick && in_body),
    .bit_i    (shift_q[39]),
    .crc_o    (crc)
  );

  // Frame body: start bit 0, transmission bit 1, index, argument
  always_ff @(posedge clk_i) begin
    if (start_tx_i && !busy_q) begin
      shift_q <= {1'b0, 1'b1, req_i.index, req_i.arg};
    end else if (tick && in_body) begin
      shift_q <= {shift_q[38:0], 1'b0};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q    <= 1'b0;
      bit_cnt_q <= '0;
      cmd_q     <= 1'b1;
      cmd_en_q  <= 1'b0;
      tx_done_q <= 1'b0;
    end else begin
      tx_done_q <= 1'b0;
      if (start_tx_i && !busy_q) begin
        busy_q    <= 1'b1;
        bit_cnt_q <= '0;
      end else if (tick) begin
        if (bit_cnt_q == 6'd48) begin
          // End bit has been on the line for a full tick
          busy_q    <= 1'b0;
          cmd_q     <= 1'b1;
          cmd_en_q  <= 1'b0;
          tx_done_q <= 1'b1;
        end else begin
          cmd_q     <= next_bit;
          cmd_en_q  <= 1'b1;
          bit_cnt_q <= bit_cnt_q + 6'd1;
        end
      end
    end
  end

  assign cmd_o     = cmd_q;
  assign cmd_en_o  = cmd_en_q;
  assign tx_done_o = tx_done_q;

endmodule

`default_nettype wire

// ==== crc7.sv ====
/*
 * Bit-serial CRC7 (x^7 + x^3 + 1) used on the CMD line.
 * Pulse clr_i before a frame, then shift_i once per covered bit.
 */
`timescale 1ns/1ps
`default_nettype none

module crc7 (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       clr_i,
  input  logic       shift_i,
  input  logic       bit_i,
  output logic [6:0] crc_o
);

  logic [6:0] crc_q;
  logic       feedback;

  assign feedback = bit_i ^ crc_q[6];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      crc_q <= '0;
    end else if (clr_i) begin
      crc_q <= '0;
    end else if (shift_i) begin
      // Taps at bit 0 and bit 3
      crc_q <= {crc_q[5:3], crc_q[2] ^ feedback, crc_q[1:0], feedback};
    end
  end

  assign crc_o = crc_q;

endmodule

`default_nettype wire

// ==== sdhci_pkg.sv ====
/*
 * Shared types and timing constants for the SD command-line engine.
 * Modules use the scoped names in their port lists and import the
 * package in their body when they need the enum values or constants.
 */
`default_nettype none

package sdhci_pkg;

  typedef logic [5:0]  cmd_t;
  typedef logic [31:0] cmd_arg_t;

  typedef enum logic [1:0] {
    NO_RESPONSE,
    RESPONSE_LENGTH_48,
    RESPONSE_LENGTH_48_CHECK_BUSY,
    RESPONSE_LENGTH_136
  } response_type_e;

  // Host request, latched by the sequencer and handed to the serializer
  typedef struct packed {
    cmd_t           index;
    cmd_arg_t       arg;
    response_type_e rsp_type;
  } cmd_req_t;

  // R1/R1b content as it lands in the low bits of the capture register
  typedef struct packed {
    logic [81:0] pad;
    cmd_t        index;
    logic [31:0] status;
  } rsp_short_t;

  // Long view is the raw CID/CSD payload of R2 without its CRC
  typedef union packed {
    logic [119:0] raw;
    rsp_short_t   short_rsp;
  } rsp_t;

  typedef struct packed {
    logic index_err;
    logic crc_err;
    logic end_bit_err;
    logic timeout;
  } rsp_err_t;

  // Bus timing in SD clock ticks
  localparam logic [6:0] N_CR_MIN = 7'd2;   // command end to earliest response
  localparam logic [6:0] N_CR_MAX = 7'd64;  // command end to latest response
  localparam logic [6:0] N_ID     = 7'd5;   // identification response window
  localparam logic [6:0] N_RC     = 7'd8;   // response end to next command
  localparam logic [6:0] N_CC     = 7'd8;   // command end to next command

  // CMD2 uses the short identification timeout
  localparam cmd_t CMD_ALL_SEND_CID = 6'd2;

endpackage

`default_nettype wire
